// File: hw/newton_step.sv
`timescale 1ns/1ps

module newton_step import rsqrt_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  fix_t x_in,
    input  fix_t a_in,
    output fix_t x_out,
    output fix_t a_out
);

    // x_next = x/2 * (3 - a * x^2)
    prod_t sq_s1, sq_s2;
    prod_t ay_s1, ay_s2;
    prod_t nx_s1, nx_s2;
    fix_t  a_d2;
    fix_t  x_d5;
    fix_t  w;
    fix_t  y;
    fix_t  z;
    fix_t  x_half;

    // operand meets the squared value after the first multiply
    pipe_delay #(.DEPTH(MUL_LAT), .payload_t(fix_t)) u_a_mul (
        .clk(clk), .rst(rst), .d(a_in), .q(a_d2)
    );

    // rest of the step, so a_out pairs with x_out
    pipe_delay #(.DEPTH(STEP_LAT - MUL_LAT), .payload_t(fix_t)) u_a_out (
        .clk(clk), .rst(rst), .d(a_d2), .q(a_out)
    );

    // x waits for square, product and subtract
    pipe_delay #(.DEPTH(STEP_LAT - MUL_LAT), .payload_t(fix_t)) u_x_dly (
        .clk(clk), .rst(rst), .d(x_in), .q(x_d5)
    );

    // Q4.52 back to Q2.26
    assign w = sq_s2[PROD_W-3 -: FIX_W];
    assign y = ay_s2[PROD_W-3 -: FIX_W];
    assign x_out = nx_s2[PROD_W-3 -: FIX_W];
    assign x_half = x_d5 >> 1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sq_s1 <= '0;
            sq_s2 <= '0;
            ay_s1 <= '0;
            ay_s2 <= '0;
            z <= '0;
            nx_s1 <= '0;
            nx_s2 <= '0;
        end else begin
            sq_s1 <= x_in * x_in;
            sq_s2 <= sq_s1;
            ay_s1 <= a_d2 * w;
            ay_s2 <= ay_s1;
            z <= THREE_FIX - y;
            nx_s1 <= x_half * z;
            nx_s2 <= nx_s1;
        end
    end

    // seed accuracy upstream keeps a*x^2 close to one
    a_y_below_three: assert property (@(posedge clk) disable iff (rst) y <= THREE_FIX);

endmodule

// File: hw/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
    parameter int  DEPTH = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);

    payload_t stage [DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

// File: hw/result_credit_fifo.sv
`timescale 1ns/1ps

module result_credit_fifo import rsqrt_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  rsqrt_rsp_t push_data,
    input  logic       rsp_credit,
    output logic       rsp_valid,
    output rsqrt_rsp_t rsp,
    output logic       req_credit
);

    rsqrt_rsp_t          mem [RESULT_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [COUNT_W-1:0]  count;
    logic [CREDIT_W-1:0] credits;

    // pop whenever something is queued and the consumer has room
    assign rsp_valid = (count != '0) && (credits != '0);
    assign rsp = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credits <= CREDIT_W'(OUT_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rsp_valid) begin
                rd_ptr <= (rd_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + COUNT_W'(push) - COUNT_W'(rsp_valid);
            credits <= credits + CREDIT_W'(rsp_credit) - CREDIT_W'(rsp_valid);
        end
    end

    // each pop hands one credit back to the sender one cycle later
    pipe_delay #(.DEPTH(1), .payload_t(logic)) u_credit_ret (
        .clk(clk), .rst(rst), .d(rsp_valid), .q(req_credit)
    );

    // sender credits must cover the whole pipeline plus the queue
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> count < COUNT_W'(RESULT_DEPTH));

    // consumer returns no more than it was given
    credits_bounded: assert property (@(posedge clk) disable iff (rst)
        credits <= CREDIT_W'(OUT_CREDITS));

endmodule

// File: hw/rsqrt_classify.sv
`timescale 1ns/1ps

module rsqrt_classify import rsqrt_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  rsqrt_req_t          req,
    output side_t               side,
    output fix_t                operand,
    output logic [LUT_BITS-1:0] lut_index,
    output logic                exp_even
);

    fp32_t      op;
    logic       man_zero;
    logic       is_qnan;
    logic       is_snan;
    logic       is_inf;
    logic       is_flush;
    logic       even_c;
    logic [8:0] exp_calc;
    side_t      side_c;
    fix_t       operand_q;

    assign op = req.operand;
    assign man_zero = (op.mantissa == '0);
    assign is_qnan = (op.exponent == '1) && !man_zero && op.mantissa[22];
    assign is_snan = (op.exponent == '1) && !man_zero && !op.mantissa[22];
    assign is_inf = (op.exponent == '1) && man_zero;
    // zero and denormals are both flushed
    assign is_flush = (op.exponent == '0);

    // even biased exponent means an odd true exponent, so the mantissa is doubled
    assign even_c = ~op.exponent[0];
    // result assumed in [0.5,1), normalization adds one when it hits 1.0
    assign exp_calc = (even_c ? 9'd380 : 9'd379) - {1'b0, op.exponent};

    always_comb begin
        side_c = '0;
        side_c.valid = req_valid;
        side_c.mode = req.mode;
        side_c.sign = op.sign;
        side_c.base_exp = exp_calc[8:1];
        side_c.special = 1'b1;
        if (is_qnan) begin
            side_c.special_result = op;
        end else if (is_snan) begin
            side_c.special_result = op;
            side_c.special_result.mantissa[22] = 1'b1;
            side_c.invalid = 1'b1;
        end else if (is_flush) begin
            side_c.special_result = {op.sign, 8'hFF, 23'd0};
            side_c.div_by_zero = 1'b1;
        end else if (op.sign) begin
            side_c.special_result = QNAN_NEG;
            side_c.invalid = 1'b1;
        end else if (is_inf) begin
            side_c.special_result = '0;
        end else begin
            side_c.special = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            side <= '0;
            lut_index <= '0;
            exp_even <= 1'b0;
            operand_q <= '0;
            operand <= '0;
        end else begin
            side <= side_c;
            lut_index <= op.mantissa[22 -: LUT_BITS];
            exp_even <= even_c;
            operand_q <= even_c ? {1'b1, op.mantissa, 4'd0} : {2'b01, op.mantissa, 3'd0};
            // one extra stage so the operand lines up with the registered seed
            operand <= operand_q;
        end
    end

endmodule

// File: hw/rsqrt_pkg.sv
package rsqrt_pkg;

    // Q2.26 Newton datapath, products come out as Q4.52
    localparam int FIX_W = 28;
    localparam int PROD_W = 2 * FIX_W;
    localparam int LUT_BITS = 8;

    // latencies in cycles
    localparam int MUL_LAT = 2;
    localparam int STEP_LAT = 7;
    localparam int CORE_LAT = 1 + 2 * STEP_LAT;

    // result queue depth doubles as the sender's starting credit count
    localparam int RESULT_DEPTH = 20;
    localparam int OUT_CREDITS = 4;
    localparam int PTR_W = $clog2(RESULT_DEPTH);
    localparam int COUNT_W = $clog2(RESULT_DEPTH + 1);
    localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

    typedef logic [FIX_W-1:0] fix_t;
    typedef logic [PROD_W-1:0] prod_t;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_t;

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011
    } round_mode_t;

    typedef struct packed {
        fp32_t       operand;
        round_mode_t mode;
    } rsqrt_req_t;

    typedef struct packed {
        fp32_t result;
        logic  invalid;
        logic  div_by_zero;
        logic  inexact;
    } rsqrt_rsp_t;

    // control that rides next to the mantissa path
    typedef struct packed {
        logic        valid;
        round_mode_t mode;
        logic        sign;
        logic        special;
        fp32_t       special_result;
        logic        invalid;
        logic        div_by_zero;
        logic [7:0]  base_exp;
    } side_t;

    localparam fix_t THREE_FIX = fix_t'(3) << (FIX_W - 2);
    localparam fp32_t QNAN_NEG = 32'hFFC00000;

endpackage

// File: hw/rsqrt_round.sv
`timescale 1ns/1ps

module rsqrt_round import rsqrt_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  fix_t       x,
    input  side_t      side,
    output logic       push,
    output rsqrt_rsp_t rsp
);

    logic        at_one;
    logic [22:0] mant_pre;
    logic        guard;
    logic        rnd;
    logic        sticky;
    logic        inexact;
    logic        round_up;
    logic [23:0] mant_rnd;
    logic [7:0]  exp_out;

    always_comb begin
        // x sits in (0.5,1], bit 26 is the integer one
        at_one = x[FIX_W-2];
        if (at_one) begin
            mant_pre = x[FIX_W-3 -: 23];
            guard = x[2];
            rnd = x[1];
            sticky = x[0];
        end else begin
            mant_pre = x[FIX_W-4 -: 23];
            guard = x[1];
            rnd = x[0];
            sticky = 1'b0;
        end
        inexact = guard | rnd | sticky;

        case (side.mode)
            RNE: round_up = guard & (rnd | sticky | mant_pre[0]);
            RTZ: round_up = 1'b0;
            RDN: round_up = side.sign & inexact;
            RUP: round_up = ~side.sign & inexact;
            default: round_up = 1'b0;
        endcase

        mant_rnd = {1'b0, mant_pre} + 24'(round_up);
        // a mantissa carry leaves zeros below and bumps the exponent
        exp_out = side.base_exp + 8'(at_one) + 8'(mant_rnd[23]);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= side.valid;
        end
    end

    always_ff @(posedge clk) begin
        rsp.invalid <= side.invalid;
        rsp.div_by_zero <= side.div_by_zero;
        if (side.special) begin
            rsp.result <= side.special_result;
            rsp.inexact <= 1'b0;
        end else begin
            rsp.result <= {side.sign, exp_out, mant_rnd[22:0]};
            rsp.inexact <= inexact;
        end
    end

endmodule

// File: hw/rsqrt_seed_lut.sv
`timescale 1ns/1ps

module rsqrt_seed_lut import rsqrt_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [LUT_BITS-1:0] index,
    input  logic                exp_even,
    output fix_t                seed
);

    localparam int ENTRIES = 1 << LUT_BITS;

    fix_t lut_odd [ENTRIES];
    fix_t lut_even [ENTRIES];
    fix_t odd_q;
    fix_t even_q;
    logic even_q_sel;

    // 1/sqrt at the midpoint of each bucket, in Q2.26
    initial begin : fill_tables
        real mid;
        for (int i = 0; i < ENTRIES; i++) begin
            mid = 1.0 + (i + 0.5) / ENTRIES;
            lut_odd[i] = fix_t'($rtoi(67108864.0 / $sqrt(mid)));
            lut_even[i] = fix_t'($rtoi(67108864.0 / $sqrt(2.0 * mid)));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            odd_q <= '0;
            even_q <= '0;
            even_q_sel <= 1'b0;
        end else begin
            odd_q <= lut_odd[index];
            even_q <= lut_even[index];
            even_q_sel <= exp_even;
        end
    end

    assign seed = even_q_sel ? even_q : odd_q;

endmodule

// File: hw/rsqrt_top.sv
`timescale 1ns/1ps

module rsqrt_top import rsqrt_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  rsqrt_req_t req,
    output logic       req_credit,
    output logic       rsp_valid,
    output rsqrt_rsp_t rsp,
    input  logic       rsp_credit
);

    side_t               side_in;
    side_t               side_out;
    fix_t                operand;
    logic [LUT_BITS-1:0] lut_index;
    logic                exp_even;
    fix_t                seed;
    fix_t                x1;
    fix_t                a1;
    fix_t                x2;
    logic                push;
    rsqrt_rsp_t          push_data;

    rsqrt_classify u_classify (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
        .side(side_in), .operand(operand), .lut_index(lut_index), .exp_even(exp_even)
    );

    rsqrt_seed_lut u_seed_lut (
        .clk(clk), .rst(rst), .index(lut_index), .exp_even(exp_even), .seed(seed)
    );

    newton_step u_step0 (
        .clk(clk), .rst(rst), .x_in(seed), .a_in(operand), .x_out(x1), .a_out(a1)
    );

    newton_step u_step1 (
        .clk(clk), .rst(rst), .x_in(x1), .a_in(a1), .x_out(x2), .a_out()
    );

    // control follows the seed lookup and both iterations
    pipe_delay #(.DEPTH(CORE_LAT), .payload_t(side_t)) u_side_dly (
        .clk(clk), .rst(rst), .d(side_in), .q(side_out)
    );

    rsqrt_round u_round (
        .clk(clk), .rst(rst), .x(x2), .side(side_out), .push(push), .rsp(push_data)
    );

    result_credit_fifo u_fifo (
        .clk(clk), .rst(rst), .push(push), .push_data(push_data), .rsp_credit(rsp_credit),
        .rsp_valid(rsp_valid), .rsp(rsp), .req_credit(req_credit)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the reciprocal square root testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_rsqrt -f vlog.f -o tb_rsqrt
./obj_dir/tb_rsqrt | tee sim.log

# pass only when the testbench printed its pass line
grep -q "^TEST OK$" sim.log

// File: tb/tb_rsqrt.sv
`timescale 1ns/1ps

module tb_rsqrt import rsqrt_pkg::*; ();

    localparam int NUM_ENTRIES = 31;
    localparam int TIMEOUT_CYCLES = 60 * NUM_ENTRIES + 300;
    localparam int STARVE_LIMIT = 80;
    localparam int HOLD_CYCLES = 40;

    typedef struct packed {
        rsqrt_req_t req;
        logic       special;
        rsqrt_rsp_t exp_rsp;
    } stim_t;

    logic       clk;
    logic       rst;
    logic       req_valid;
    rsqrt_req_t req;
    logic       req_credit;
    logic       rsp_valid;
    rsqrt_rsp_t rsp;
    logic       rsp_credit;

    stim_t  stim_tab [NUM_ENTRIES];
    int     n_entries;
    int     errors;
    integer seed;

    rsqrt_top u_rsqrt_top (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req), .req_credit(req_credit),
        .rsp_valid(rsp_valid), .rsp(rsp), .rsp_credit(rsp_credit)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("Error: %s got %h expected %h", name, got, want);
    endtask

    task automatic add_special(input logic [31:0] op, input logic [31:0] res,
                               input logic inv, input logic dbz);
        stim_tab[n_entries] = '0;
        stim_tab[n_entries].req.operand = op;
        stim_tab[n_entries].req.mode = RNE;
        stim_tab[n_entries].special = 1'b1;
        stim_tab[n_entries].exp_rsp.result = res;
        stim_tab[n_entries].exp_rsp.invalid = inv;
        stim_tab[n_entries].exp_rsp.div_by_zero = dbz;
        n_entries++;
    endtask

    // one entry per rounding mode
    task automatic add_numeric(input logic [31:0] op);
        for (int k = 0; k < 4; k++) begin
            stim_tab[n_entries] = '0;
            stim_tab[n_entries].req.operand = op;
            stim_tab[n_entries].req.mode = round_mode_t'(k);
            n_entries++;
        end
    endtask

    task automatic build_table();
        add_special(32'h7FC00001, 32'h7FC00001, 1'b0, 1'b0);
        add_special(32'h7F800001, 32'h7FC00001, 1'b1, 1'b0);
        add_special(32'h00000000, 32'h7F800000, 1'b0, 1'b1);
        add_special(32'h00000010, 32'h7F800000, 1'b0, 1'b1);
        add_special(32'h80000000, 32'hFF800000, 1'b0, 1'b1);
        add_special(32'hBF800000, 32'hFFC00000, 1'b1, 1'b0);
        add_special(32'h7F800000, 32'h00000000, 1'b0, 1'b0);
        add_numeric(32'h3F800000);
        add_numeric(32'h40800000);
        add_numeric(32'h40000000);
        add_numeric(32'h3E800000);
        add_numeric(32'h40400000);
        add_numeric(32'h4640E6B6);
    endtask

    // normal numbers only
    function automatic real fp_value(input fp32_t f);
        real v;
        int  e;
        v = 1.0 + f.mantissa / 8388608.0;
        e = int'(f.exponent) - 127;
        while (e > 0) begin
            v = v * 2.0;
            e--;
        end
        while (e < 0) begin
            v = v * 0.5;
            e++;
        end
        return f.sign ? -v : v;
    endfunction

    // float just below a positive real
    function automatic logic [31:0] fp_bits(input real v);
        int  e;
        real m;
        e = 127;
        m = v;
        while (m >= 2.0) begin
            m = m / 2.0;
            e++;
        end
        while (m < 1.0) begin
            m = m * 2.0;
            e--;
        end
        return {1'b0, 8'(e), 23'($rtoi((m - 1.0) * 8388608.0))};
    endfunction

    task automatic check_response(input int idx);
        stim_t       s;
        real         got;
        real         want;
        real         ulp;
        logic [31:0] want_bits;
        s = stim_tab[idx];
        if (s.special) begin
            if (rsp.result !== s.exp_rsp.result)
                report_mismatch("rsp.result", rsp.result, s.exp_rsp.result);
            if (rsp.inexact !== 1'b0)
                report_mismatch("rsp.inexact", rsp.inexact, 0);
        end else begin
            got = fp_value(rsp.result);
            want = 1.0 / $sqrt(fp_value(s.req.operand));
            want_bits = fp_bits(want);
            // ulp of the exact value
            ulp = fp_value({1'b0, want_bits[30:23], 23'd0}) / 8388608.0;
            if (got - want > ulp || want - got > ulp)
                report_mismatch("rsp.result", rsp.result, want_bits);
            // half an ulp of slack covers the truncating fixed-point datapath
            if ((s.req.mode == RTZ || s.req.mode == RDN) && got > want + ulp / 2.0) begin
                errors++;
                $display("Error: rsp.result %h above exact %h in mode %0d",
                         rsp.result, want_bits, s.req.mode);
            end
            if (s.req.mode == RUP && got < want - ulp / 2.0) begin
                errors++;
                $display("Error: rsp.result %h below exact %h in mode %0d",
                         rsp.result, want_bits, s.req.mode);
            end
        end
        if (rsp.invalid !== s.exp_rsp.invalid)
            report_mismatch("rsp.invalid", rsp.invalid, s.exp_rsp.invalid);
        if (rsp.div_by_zero !== s.exp_rsp.div_by_zero)
            report_mismatch("rsp.div_by_zero", rsp.div_by_zero, s.exp_rsp.div_by_zero);
    endtask

    initial begin
        int   sent;
        int   received;
        int   returned;
        int   credits;
        int   credit_pulses;
        int   starve;
        int   cycle;
        int   tail;
        logic timed_out;
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_credit = 1'b0;
        seed = 32'h88bd66b4;
        errors = 0;
        n_entries = 0;
        sent = 0;
        received = 0;
        returned = 0;
        credits = RESULT_DEPTH;
        credit_pulses = 0;
        starve = 0;
        cycle = 0;
        tail = 0;
        timed_out = 1'b0;
        build_table();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // nothing may come out before the first request
        repeat (8) begin
            @(negedge clk);
            if (rsp_valid !== 1'b0)
                report_mismatch("rsp_valid", rsp_valid, 0);
            if (req_credit !== 1'b0)
                report_mismatch("req_credit", req_credit, 0);
        end

        while (!timed_out && tail < 20) begin
            @(negedge clk);
            cycle++;
            if (req_credit === 1'b1) begin
                credits++;
                credit_pulses++;
            end
            if (rsp_valid === 1'b1) begin
                if (received >= OUT_CREDITS + returned) begin
                    errors++;
                    $display("response handed out without a consumer credit at cycle %0d", cycle);
                end
                if (received < NUM_ENTRIES) begin
                    check_response(received);
                end else begin
                    errors++;
                    $display("response beyond the last request at cycle %0d", cycle);
                end
                received++;
            end

            // consumer holds its credits at first, then returns them at random
            rsp_credit = 1'b0;
            if (cycle > HOLD_CYCLES && received > returned && ($random(seed) & 1) == 0) begin
                rsp_credit = 1'b1;
                returned++;
            end

            // driver spends one credit per request and idles at random
            req_valid = 1'b0;
            req = '0;
            if (sent < NUM_ENTRIES && credits > 0 && ($random(seed) & 3) != 0) begin
                req_valid = 1'b1;
                req = stim_tab[sent].req;
                sent++;
                credits--;
            end
            if (sent < NUM_ENTRIES && credits == 0)
                starve++;
            else
                starve = 0;
            if (starve == STARVE_LIMIT) begin
                errors++;
                $display("driver held no credit for %0d cycles", STARVE_LIMIT);
            end

            if (received == NUM_ENTRIES && credits == RESULT_DEPTH)
                tail++;
            if (cycle >= TIMEOUT_CYCLES)
                timed_out = 1'b1;
        end

        if (timed_out) begin
            errors++;
            $display("timeout after %0d cycles with %0d of %0d responses",
                     cycle, received, NUM_ENTRIES);
        end
        if (credit_pulses != received) begin
            errors++;
            $display("req_credit pulsed %0d times for %0d responses", credit_pulses, received);
        end
        if (credits != RESULT_DEPTH) begin
            errors++;
            $display("sender holds %0d of %0d credits at the end", credits, RESULT_DEPTH);
        end
        $display("errors %0d, responses %0d of %0d, credit returns %0d",
                 errors, received, NUM_ENTRIES, credit_pulses);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/rsqrt_pkg.sv
hw/pipe_delay.sv
hw/rsqrt_classify.sv
hw/rsqrt_seed_lut.sv
hw/newton_step.sv
hw/rsqrt_round.sv
hw/result_credit_fifo.sv
hw/rsqrt_top.sv
tb/tb_rsqrt.sv
